//--- Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_pkg.sv
      - hdl/rv_fetch.sv
      - hdl/rv_decoder.sv
      - hdl/rv_regfile.sv
      - hdl/rv_alu.sv
      - hdl/rv_writeback.sv
      - hdl/rv_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/tb_clock.sv
      - tests/tb_rv_core.sv

//--- hdl/rv_alu.sv
`default_nettype none
`include "rv_defines.svh"

module rv_alu (
	input  rv_pkg::alu_op_e  op,
	input  logic [`XLEN-1:0] a,
	input  logic [`XLEN-1:0] b,
	output logic [`XLEN-1:0] result
);

	logic [4:0] shamt;

	assign shamt = b[4:0];  // Upper bits of b ignored for shifts

	always_comb begin
		case (op)
			rv_pkg::ALU_ADD:    result = a + b;
			rv_pkg::ALU_SUB:    result = a - b;
			rv_pkg::ALU_SLL:    result = a << shamt;
			rv_pkg::ALU_SLT:    result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			rv_pkg::ALU_SLTU:   result = {{(`XLEN-1){1'b0}}, a < b};
			rv_pkg::ALU_XOR:    result = a ^ b;
			rv_pkg::ALU_SRL:    result = a >> shamt;
			rv_pkg::ALU_SRA:    result = $signed(a) >>> shamt;  // Sign fill
			rv_pkg::ALU_OR:     result = a | b;
			rv_pkg::ALU_AND:    result = a & b;
			rv_pkg::ALU_PASS_B: result = b;
			default:            result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/rv_core.sv
`default_nettype none
`include "rv_defines.svh"

module rv_core (
	input  logic             clk,
	input  logic             reset,
	output logic [`XLEN-1:0] imem_addr,
	input  logic [`XLEN-1:0] imem_data,
	output logic [`XLEN-1:0] dmem_addr,
	output logic [`XLEN-1:0] dmem_wdata,
	output logic             dmem_we,
	input  logic [`XLEN-1:0] dmem_rdata
);

	rv_pkg::inst_u      inst;
	rv_pkg::alu_op_e    alu_op;
	rv_pkg::wb_sel_e    wb_sel;
	rv_pkg::load_type_e load_type;
	logic [`XLEN-1:0]   pc;
	logic [`XLEN-1:0]   pc_plus4;
	logic [`XLEN-1:0]   imm;
	logic [`XLEN-1:0]   rs1_data;
	logic [`XLEN-1:0]   rs2_data;
	logic [`XLEN-1:0]   alu_a;
	logic [`XLEN-1:0]   alu_b;
	logic [`XLEN-1:0]   alu_result;
	logic [`XLEN-1:0]   rd_wdata;
	logic               a_sel;
	logic               b_sel;
	logic               reg_we;
	logic               branch_taken;

	assign inst       = rv_pkg::inst_u'(imem_data);
	assign imem_addr  = pc;
	assign alu_a      = a_sel ? pc : rs1_data;
	assign alu_b      = b_sel ? imm : rs2_data;
	assign dmem_addr  = alu_result;  // Byte address
	assign dmem_wdata = rs2_data;

	rv_fetch u_fetch (
		.clk(clk), .reset(reset), .branch_taken(branch_taken),
		.target(alu_result), .pc(pc), .pc_plus4(pc_plus4)
	);

	rv_decoder u_decoder (
		.reset(reset), .inst(inst), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.imm(imm), .alu_op(alu_op), .a_sel(a_sel), .b_sel(b_sel), .reg_we(reg_we),
		.dmem_we(dmem_we), .branch_taken(branch_taken), .wb_sel(wb_sel),
		.load_type(load_type)
	);

	rv_regfile u_regfile (
		.clk(clk), .reset(reset), .we(reg_we), .rd(inst.r.rd), .rs1(inst.r.rs1),
		.rs2(inst.r.rs2), .wdata(rd_wdata), .rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	rv_alu u_alu (.op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result));

	rv_writeback u_writeback (
		.wb_sel(wb_sel), .load_type(load_type), .load_word(dmem_rdata),
		.alu_result(alu_result), .pc_plus4(pc_plus4), .wdata(rd_wdata)
	);

	// Word stores need a word aligned byte address
	assert property (@(posedge clk) disable iff (reset)
		dmem_we |-> dmem_addr[1:0] == 2'b00)
		else $error("Store address not word aligned: %h", dmem_addr);

endmodule

`default_nettype wire

//--- hdl/rv_decoder.sv
`default_nettype none
`include "rv_defines.svh"

module rv_decoder (
	input  logic                 reset,
	input  rv_pkg::inst_u        inst,
	input  logic [`XLEN-1:0]     rs1_data,
	input  logic [`XLEN-1:0]     rs2_data,
	output logic [`XLEN-1:0]     imm,
	output rv_pkg::alu_op_e      alu_op,
	output logic                 a_sel,
	output logic                 b_sel,
	output logic                 reg_we,
	output logic                 dmem_we,
	output logic                 branch_taken,
	output rv_pkg::wb_sel_e      wb_sel,
	output rv_pkg::load_type_e   load_type
);

	rv_pkg::imm_sel_e imm_sel;
	rv_pkg::alu_op_e  arith_op;
	logic [2:0]       funct3;
	logic             br_eq;
	logic             br_lt;
	logic             br_ltu;
	logic             cond_met;

	assign funct3 = inst.r.funct3;
	assign br_eq  = (rs1_data == rs2_data);
	assign br_lt  = ($signed(rs1_data) < $signed(rs2_data));
	assign br_ltu = (rs1_data < rs2_data);

	always_comb begin
		case (funct3)
			3'b000:  cond_met = br_eq;    // BEQ
			3'b001:  cond_met = !br_eq;   // BNE
			3'b100:  cond_met = br_lt;    // BLT
			3'b101:  cond_met = !br_lt;   // BGE
			3'b110:  cond_met = br_ltu;   // BLTU
			3'b111:  cond_met = !br_ltu;  // BGEU
			default: cond_met = 1'b0;
		endcase
	end

	// Shared by OP and OP-IMM, SUB is picked out below
	always_comb begin
		case (funct3)
			3'b000:  arith_op = rv_pkg::ALU_ADD;
			3'b001:  arith_op = rv_pkg::ALU_SLL;
			3'b010:  arith_op = rv_pkg::ALU_SLT;
			3'b011:  arith_op = rv_pkg::ALU_SLTU;
			3'b100:  arith_op = rv_pkg::ALU_XOR;
			3'b101:  arith_op = inst.r.funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
			3'b110:  arith_op = rv_pkg::ALU_OR;
			default: arith_op = rv_pkg::ALU_AND;
		endcase
	end

	always_comb begin
		imm_sel      = rv_pkg::IMM_I;
		alu_op       = rv_pkg::ALU_ADD;
		a_sel        = 1'b0;  // rs1
		b_sel        = 1'b0;  // rs2
		reg_we       = 1'b0;
		dmem_we      = 1'b0;
		branch_taken = 1'b0;
		wb_sel       = rv_pkg::WB_ALU;
		load_type    = rv_pkg::LD_W;
		case (inst.r.opcode)
			`OP_RTYPE: begin
				reg_we = 1'b1;
				alu_op = (funct3 == 3'b000 && inst.r.funct7[5]) ? rv_pkg::ALU_SUB : arith_op;
			end
			`OP_ITYPE: begin
				reg_we = 1'b1;
				b_sel  = 1'b1;
				alu_op = arith_op;  // Bit 30 only matters for SRAI
			end
			`OP_LOAD: begin
				reg_we    = 1'b1;
				b_sel     = 1'b1;
				wb_sel    = rv_pkg::WB_LOAD;
				load_type = rv_pkg::load_type_e'(funct3);
			end
			`OP_STORE: begin
				imm_sel = rv_pkg::IMM_S;
				b_sel   = 1'b1;
				dmem_we = 1'b1;  // Word store only
			end
			`OP_BRANCH: begin
				imm_sel      = rv_pkg::IMM_B;
				a_sel        = 1'b1;  // PC + offset
				b_sel        = 1'b1;
				branch_taken = cond_met;
			end
			`OP_JAL: begin
				imm_sel      = rv_pkg::IMM_J;
				a_sel        = 1'b1;
				b_sel        = 1'b1;
				reg_we       = 1'b1;
				wb_sel       = rv_pkg::WB_PC_PLUS4;
				branch_taken = 1'b1;
			end
			`OP_JALR: begin
				b_sel        = 1'b1;
				reg_we       = 1'b1;
				wb_sel       = rv_pkg::WB_PC_PLUS4;
				branch_taken = 1'b1;
			end
			`OP_LUI: begin
				imm_sel = rv_pkg::IMM_U;
				b_sel   = 1'b1;
				reg_we  = 1'b1;
				alu_op  = rv_pkg::ALU_PASS_B;
			end
			`OP_AUIPC: begin
				imm_sel = rv_pkg::IMM_U;
				a_sel   = 1'b1;
				b_sel   = 1'b1;
				reg_we  = 1'b1;
			end
			default: begin
				reg_we = 1'b0;  // Unknown opcode retires as a no-op
			end
		endcase
		if (reset) begin
			reg_we  = 1'b0;
			dmem_we = 1'b0;
		end
	end

	always_comb begin
		case (imm_sel)
			rv_pkg::IMM_I: imm = {{20{inst.i.imm[11]}}, inst.i.imm};
			rv_pkg::IMM_S: imm = {{20{inst.r.funct7[6]}}, inst.r.funct7, inst.r.rd};
			rv_pkg::IMM_B: imm = {{20{inst.raw[31]}}, inst.raw[7], inst.raw[30:25],
					inst.raw[11:8], 1'b0};
			rv_pkg::IMM_J: imm = {{12{inst.raw[31]}}, inst.raw[19:12], inst.raw[20],
					inst.raw[30:21], 1'b0};
			rv_pkg::IMM_U: imm = {inst.raw[31:12], 12'b0};
			default:       imm = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Datapath and register file sizing
`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32

`define RESET_PC    32'h0000_0000  // First fetch address

// Major opcodes, inst[6:0]
`define OP_RTYPE    7'b0110011
`define OP_ITYPE    7'b0010011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111

`endif

//--- hdl/rv_fetch.sv
`default_nettype none
`include "rv_defines.svh"

module rv_fetch (
	input  logic             clk,
	input  logic             reset,
	input  logic             branch_taken,
	input  logic [`XLEN-1:0] target,
	output logic [`XLEN-1:0] pc,
	output logic [`XLEN-1:0] pc_plus4
);

	assign pc_plus4 = pc + `XLEN'(4);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= `RESET_PC;
		end else if (branch_taken) begin
			pc <= target;  // Branch or jump target from the ALU
		end else begin
			pc <= pc_plus4;
		end
	end

	// Every target the decoder and ALU hand back must keep word alignment
	assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
		else $error("PC not word aligned: %h", pc);

endmodule

`default_nettype wire

//--- hdl/rv_pkg.sv
`default_nettype none
`include "rv_defines.svh"

package rv_pkg;

	// Bit 3 marks the alternate form (SUB, SRA)
	typedef enum logic [3:0] {
		ALU_ADD    = 4'b0000,
		ALU_SLL    = 4'b0001,
		ALU_SLT    = 4'b0010,
		ALU_SLTU   = 4'b0011,
		ALU_XOR    = 4'b0100,
		ALU_SRL    = 4'b0101,
		ALU_OR     = 4'b0110,
		ALU_AND    = 4'b0111,
		ALU_SUB    = 4'b1000,
		ALU_SRA    = 4'b1101,
		ALU_PASS_B = 4'b1111   // LUI
	} alu_op_e;

	typedef enum logic [2:0] {
		IMM_I = 3'b000,
		IMM_S = 3'b001,
		IMM_B = 3'b010,
		IMM_J = 3'b011,
		IMM_U = 3'b100
	} imm_sel_e;

	typedef enum logic [1:0] {
		WB_LOAD     = 2'b00,
		WB_ALU      = 2'b01,
		WB_PC_PLUS4 = 2'b10
	} wb_sel_e;

	// Same values as the load funct3
	typedef enum logic [2:0] {
		LD_B  = 3'b000,
		LD_H  = 3'b001,
		LD_W  = 3'b010,
		LD_BU = 3'b100,
		LD_HU = 3'b101
	} load_type_e;

	typedef struct packed {
		logic [6:0]             funct7;
		logic [`REG_ADDR_W-1:0] rs2;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [2:0]             funct3;
		logic [`REG_ADDR_W-1:0] rd;
		logic [6:0]             opcode;
	} inst_r_t;

	typedef struct packed {
		logic [11:0]            imm;     // inst[31:20]
		logic [`REG_ADDR_W-1:0] rs1;
		logic [2:0]             funct3;
		logic [`REG_ADDR_W-1:0] rd;
		logic [6:0]             opcode;
	} inst_i_t;

	typedef union packed {
		logic [`XLEN-1:0] raw;
		inst_r_t          r;
		inst_i_t          i;
	} inst_u;

endpackage

`default_nettype wire

//--- hdl/rv_regfile.sv
`default_nettype none
`include "rv_defines.svh"

module rv_regfile (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   we,
	input  logic [`REG_ADDR_W-1:0] rd,
	input  logic [`REG_ADDR_W-1:0] rs1,
	input  logic [`REG_ADDR_W-1:0] rs2,
	input  logic [`XLEN-1:0]       wdata,
	output logic [`XLEN-1:0]       rs1_data,
	output logic [`XLEN-1:0]       rs2_data
);

	logic [`XLEN-1:0] regs [1:`NUM_REGS-1];  // x0 has no storage

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 1; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	// Read ports are combinational, x0 reads as zero
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- hdl/rv_writeback.sv
`default_nettype none
`include "rv_defines.svh"

module rv_writeback (
	input  rv_pkg::wb_sel_e    wb_sel,
	input  rv_pkg::load_type_e load_type,
	input  logic [`XLEN-1:0]   load_word,
	input  logic [`XLEN-1:0]   alu_result,
	input  logic [`XLEN-1:0]   pc_plus4,
	output logic [`XLEN-1:0]   wdata
);

	logic [`XLEN-1:0] load_value;

	// Low byte or half of the addressed word, as the memory returns it
	always_comb begin
		case (load_type)
			rv_pkg::LD_B:  load_value = {{24{load_word[7]}}, load_word[7:0]};
			rv_pkg::LD_H:  load_value = {{16{load_word[15]}}, load_word[15:0]};
			rv_pkg::LD_W:  load_value = load_word;
			rv_pkg::LD_BU: load_value = {24'b0, load_word[7:0]};
			rv_pkg::LD_HU: load_value = {16'b0, load_word[15:0]};
			default:       load_value = '0;
		endcase
	end

	always_comb begin
		case (wb_sel)
			rv_pkg::WB_LOAD:     wdata = load_value;
			rv_pkg::WB_ALU:      wdata = alu_result;
			rv_pkg::WB_PC_PLUS4: wdata = pc_plus4;  // Link address
			default:             wdata = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 100
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

//--- tests/tb_rv_core.sv
`default_nettype none
`include "rv_defines.svh"

module tb_rv_core;

	localparam int          RUN_LIMIT   = 2000;
	localparam logic [31:0] DATA_BASE   = 32'h100;
	localparam logic [31:0] RESULT_BASE = 32'h200;
	localparam logic [31:0] DONE_ADDR   = 32'h3fc;

	logic             clk;
	logic             reset = 1'b1;
	logic [`XLEN-1:0] imem_addr;
	logic [`XLEN-1:0] imem_data;
	logic [`XLEN-1:0] dmem_addr;
	logic [`XLEN-1:0] dmem_wdata;
	logic [`XLEN-1:0] dmem_rdata;
	logic             dmem_we;
	logic [31:0]      imem [0:255];
	logic [31:0]      dmem [0:255];
	logic [31:0]      exp_addr [$];
	logic [31:0]      exp_value [$];
	logic [31:0]      slot_addr;
	int               pc_idx;

	tb_clock u_clock (.clk(clk));

	rv_core u_rv_core (
		.clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
		.dmem_rdata(dmem_rdata)
	);

	assign imem_data  = imem[imem_addr[9:2]];  // Word index
	assign dmem_rdata = dmem[dmem_addr[9:2]];

	always @(posedge clk) begin
		if (dmem_we) begin
			dmem[dmem_addr[9:2]] <= dmem_wdata;
		end
	end

	function automatic logic [31:0] fill_pattern(logic [7:0] idx);
		return {8'hc3, idx, ~idx, idx};
	endfunction

	function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, `OP_RTYPE};
	endfunction

	function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
			logic [4:0] rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OP_STORE};
	endfunction

	function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OP_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
	endfunction

	// Reference results straight from the ISA definitions
	function automatic logic [31:0] alu_expect(logic [2:0] f3, logic alt, logic [31:0] a,
			logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: begin
				if (alt) begin
					return $signed(a) >>> b[4:0];
				end
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [31:0] load_expect(logic [2:0] f3, logic [31:0] w);
		case (f3)
			3'd0: return {{24{w[7]}}, w[7:0]};
			3'd1: return {{16{w[15]}}, w[15:0]};
			3'd4: return {24'b0, w[7:0]};
			3'd5: return {16'b0, w[15:0]};
			default: return w;
		endcase
	endfunction

	function automatic logic branch_expect(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
			$display("Result: FAILED");
			$fatal(1, "Stopped at first error");
		end
	endtask

	task automatic emit(logic [31:0] word);
		imem[pc_idx] = word;
		pc_idx++;
	endtask

	task automatic load_const(logic [4:0] rd, logic [31:0] value);
		logic [31:0] upper;
		upper = value + 32'h800;  // ADDI sign-extends the low part
		emit({upper[31:12], rd, `OP_LUI});
		emit(enc_i(value[11:0], rd, 3'b000, rd, `OP_ITYPE));
	endtask

	task automatic store_expect(logic [4:0] rs, logic [31:0] value);
		emit(enc_s(slot_addr[11:0], rs, 5'd0));
		exp_addr.push_back(slot_addr);
		exp_value.push_back(value);
		slot_addr += 4;
	endtask

	task automatic begin_program();
		@(posedge clk);
		reset     <= 1'b1;
		@(negedge clk);  // Core already held in reset here
		pc_idx    = 0;
		slot_addr = RESULT_BASE;
		exp_addr.delete();
		exp_value.delete();
		for (int i = 0; i < 256; i++) begin
			dmem[i] <= fill_pattern(8'(i));
		end
	endtask

	task automatic run_program(string name);
		int cycles;
		emit(enc_s(DONE_ADDR[11:0], 5'd0, 5'd0));
		emit(enc_j(21'd0, 5'd0));  // Park in a self loop
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value({name, " first fetch"}, 32'h0000_0000, imem_addr);
		cycles = 0;
		while (!(dmem_we === 1'b1 && dmem_addr == DONE_ADDR)) begin
			if (cycles >= RUN_LIMIT) begin
				$display("Timeout: %s never reached its done store in %0d cycles",
					name, RUN_LIMIT);
				$display("Result: FAILED");
				$fatal(1, "Program did not finish");
			end
			@(negedge clk);
			cycles++;
		end
		for (int i = 0; i < exp_addr.size(); i++) begin
			check_value(name, exp_value[i], dmem[exp_addr[i][9:2]]);
		end
	endtask

	task automatic test_alu();
		logic [31:0] a;
		logic [31:0] b;
		logic [11:0] imm;
		logic [4:0]  shamt;
		begin_program();
		a = $urandom | 32'h8000_0000;  // Negative against positive splits SLT and SLTU
		b = $urandom & 32'h7fff_ffff;
		load_const(5'd1, a);
		load_const(5'd2, b);
		for (int f3 = 0; f3 < 8; f3++) begin
			emit(enc_r(7'b0, 5'd2, 5'd1, 3'(f3), 5'd3));
			store_expect(5'd3, alu_expect(3'(f3), 1'b0, a, b));
			if (f3 == 0 || f3 == 5) begin
				emit(enc_r(7'b0100000, 5'd2, 5'd1, 3'(f3), 5'd4));
				store_expect(5'd4, alu_expect(3'(f3), 1'b1, a, b));
			end
		end
		for (int f3 = 0; f3 < 8; f3++) begin
			imm   = 12'($urandom);
			shamt = 5'($urandom);
			if (f3 == 1 || f3 == 5) begin
				emit(enc_i({7'b0, shamt}, 5'd1, 3'(f3), 5'd5, `OP_ITYPE));
				store_expect(5'd5, alu_expect(3'(f3), 1'b0, a, {27'b0, shamt}));
			end else begin
				emit(enc_i(imm, 5'd1, 3'(f3), 5'd5, `OP_ITYPE));
				store_expect(5'd5, alu_expect(3'(f3), 1'b0, a, {{20{imm[11]}}, imm}));
			end
			if (f3 == 5) begin
				emit(enc_i({7'b0100000, shamt}, 5'd1, 3'd5, 5'd6, `OP_ITYPE));  // SRAI
				store_expect(5'd6, alu_expect(3'd5, 1'b1, a, {27'b0, shamt}));
			end
		end
		run_program("alu");
	endtask

	task automatic test_upper();
		logic [19:0] u_lui;
		logic [19:0] u_auipc;
		logic [31:0] pc;
		begin_program();
		u_lui   = 20'($urandom);
		u_auipc = 20'($urandom);
		emit({u_lui, 5'd5, `OP_LUI});
		store_expect(5'd5, {u_lui, 12'b0});
		pc = 32'(pc_idx * 4);
		emit({u_auipc, 5'd6, `OP_AUIPC});
		store_expect(5'd6, pc + {u_auipc, 12'b0});
		run_program("lui_auipc");
	endtask

	task automatic test_loads();
		logic [31:0] words [2];
		begin_program();
		words[0] = $urandom | 32'h0000_8080;  // Byte and half sign bits set
		words[1] = $urandom & 32'hffff_7f7f;
		dmem[DATA_BASE[9:2]]     <= words[0];
		dmem[DATA_BASE[9:2] + 1] <= words[1];
		for (int w = 0; w < 2; w++) begin
			for (int f3 = 0; f3 < 6; f3++) begin
				if (f3 != 3) begin
					emit(enc_i(12'(DATA_BASE + 4 * w), 5'd0, 3'(f3), 5'd7, `OP_LOAD));
					store_expect(5'd7, load_expect(3'(f3), words[w]));
				end
			end
		end
		run_program("loads");
	endtask

	task automatic test_branches();
		logic [31:0] lhs [3];
		logic [31:0] rhs [3];
		logic [11:0] taken_mark;
		logic [11:0] fall_mark;
		lhs[0] = $urandom & 32'h7fff_ffff;
		rhs[0] = lhs[0];
		lhs[1] = $urandom | 32'h8000_0000;  // Signed less, unsigned greater
		rhs[1] = lhs[0];
		lhs[2] = lhs[0];
		rhs[2] = lhs[1];
		begin_program();
		for (int k = 0; k < 3; k++) begin
			load_const(5'd10, lhs[k]);
			load_const(5'd11, rhs[k]);
			for (int f3 = 0; f3 < 8; f3++) begin
				if (f3 != 2 && f3 != 3) begin
					taken_mark = 12'(12'h100 + k * 8 + f3);
					fall_mark  = 12'(12'h200 + k * 8 + f3);
					emit(enc_b(13'd12, 5'd11, 5'd10, 3'(f3)));
					emit(enc_i(fall_mark, 5'd0, 3'b000, 5'd8, `OP_ITYPE));
					emit(enc_j(21'd8, 5'd0));
					emit(enc_i(taken_mark, 5'd0, 3'b000, 5'd8, `OP_ITYPE));
					store_expect(5'd8, branch_expect(3'(f3), lhs[k], rhs[k]) ?
						{20'b0, taken_mark} : {20'b0, fall_mark});
				end
			end
		end
		run_program("branches");
	endtask

	task automatic test_jumps();
		logic [31:0] skip_addr;
		logic [31:0] jump_pc;
		logic [31:0] target;
		begin_program();
		skip_addr = slot_addr;  // Only the skipped stores point here
		exp_addr.push_back(skip_addr);
		exp_value.push_back(fill_pattern(skip_addr[9:2]));
		slot_addr += 4;
		emit(enc_i(12'h077, 5'd0, 3'b000, 5'd13, `OP_ITYPE));
		jump_pc = 32'(pc_idx * 4);
		emit(enc_j(21'd8, 5'd12));
		emit(enc_s(skip_addr[11:0], 5'd13, 5'd0));
		store_expect(5'd12, jump_pc + 4);
		target = 32'((pc_idx + 4) * 4);  // Two for the constant, JALR, skipped store
		load_const(5'd14, target - 4);
		jump_pc = 32'(pc_idx * 4);
		emit(enc_i(12'd4, 5'd14, 3'b000, 5'd15, `OP_JALR));
		emit(enc_s(skip_addr[11:0], 5'd13, 5'd0));
		store_expect(5'd15, jump_pc + 4);
		run_program("jumps");
	endtask

	task automatic test_zero_reg();
		logic [31:0] value;
		begin_program();
		value = $urandom | 32'd1;
		load_const(5'd1, value);
		emit(enc_i(12'h055, 5'd0, 3'b000, 5'd0, `OP_ITYPE));
		emit(enc_r(7'b0, 5'd1, 5'd1, 3'b000, 5'd0));
		emit({20'habcde, 5'd0, `OP_LUI});
		store_expect(5'd0, 32'd0);
		emit(enc_r(7'b0, 5'd1, 5'd0, 3'b000, 5'd16));  // x0 as a source
		store_expect(5'd16, value);
		run_program("zero_reg");
	endtask

	initial begin
		void'($urandom(32'h9f48_6c76));
		test_alu();
		test_upper();
		test_loads();
		test_branches();
		test_jumps();
		test_zero_reg();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_fetch.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_writeback.sv
hdl/rv_core.sv
tests/tb_clock.sv
tests/tb_rv_core.sv
